// File: src/clock_pkg.sv
// Shared widths, mode and position codes, unit limits, tick divisors and the time word
package clock_pkg;

	// ------------------------------------------------------------
	// Widths and counts
	// ------------------------------------------------------------
	localparam int UNIT_W   = 6;
	localparam int MODE_W   = 2;
	localparam int POS_W    = 2;
	localparam int N_KEYS   = 4;
	localparam int N_DIGITS = 6;
	localparam int SEG_W    = 7;	// a..g, a in the MSB

	// Last value of each unit before it wraps
	localparam logic [UNIT_W-1:0] SEC_MAX  = 6'd59;
	localparam logic [UNIT_W-1:0] MIN_MAX  = 6'd59;
	localparam logic [UNIT_W-1:0] HOUR_MAX = 6'd23;

	// Operating modes
	localparam logic [MODE_W-1:0] MODE_CLOCK = 2'd0;
	localparam logic [MODE_W-1:0] MODE_SETUP = 2'd1;
	localparam logic [MODE_W-1:0] MODE_ALARM = 2'd2;

	// Selected unit, also the index into the unit view
	localparam logic [POS_W-1:0] POS_SEC  = 2'd0;
	localparam logic [POS_W-1:0] POS_MIN  = 2'd1;
	localparam logic [POS_W-1:0] POS_HOUR = 2'd2;

	// Bit of each key in the key vector
	localparam int KEY_MODE  = 0;
	localparam int KEY_POS   = 1;
	localparam int KEY_INC   = 2;
	localparam int KEY_ALARM = 3;

	// ------------------------------------------------------------
	// Divisors for a 50 MHz clk
	// ------------------------------------------------------------
	localparam logic [31:0] SEC_DIV_DEF   = 32'd50_000_000;
	localparam logic [31:0] SCAN_DIV_DEF  = 32'd5_000;
	localparam logic [31:0] BLINK_DIV_DEF = 32'd12_500_000;
	localparam logic [31:0] KEY_DIV_DEF   = 32'd500_000;

	// Time word, read per field by the carry chain or per unit by position
	typedef union packed {
		struct packed {
			logic [UNIT_W-1:0] hour;
			logic [UNIT_W-1:0] min;
			logic [UNIT_W-1:0] sec;
		} field;
		logic [POS_HOUR:POS_SEC][UNIT_W-1:0] unit;
	} hms_time_u;

endpackage

// File: src/tick_gen.sv
// Clock divider giving a single-cycle enable pulse every DIV clocks
`timescale 1ns/1ps

module tick_gen #(
	parameter int DIV = 2
) (
	input  logic clk,
	input  logic rst_n,
	output logic o_tick
);

	localparam int CNT_W = $clog2(DIV);

	logic [CNT_W-1:0] cnt;

	// Restart on the terminal count
	always_ff @(posedge clk or negedge rst_n) begin
		if (rst_n == 1'b0) begin
			cnt <= '0;
		end else if (o_tick) begin
			cnt <= '0;
		end else begin
			cnt <= cnt + 1'b1;
		end
	end

	assign o_tick = (cnt == CNT_W'(DIV - 1));

endmodule

// File: src/key_debounce.sv
// Key sampler with two sample stages, stable state and press pulse output
`timescale 1ns/1ps

module key_debounce (
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic                         i_sample,
	input  logic [clock_pkg::N_KEYS-1:0] i_keys,
	output logic [clock_pkg::N_KEYS-1:0] o_press
);

	import clock_pkg::*;

	logic [N_KEYS-1:0] samp_1;
	logic [N_KEYS-1:0] samp_2;
	logic [N_KEYS-1:0] stable;
	logic [N_KEYS-1:0] agree;
	logic [N_KEYS-1:0] rise;

	// Two matching samples decide the stable level
	assign agree = ~(samp_1 ^ samp_2);
	assign rise  = agree & samp_1 & ~stable;

	always_ff @(posedge clk or negedge rst_n) begin
		if (rst_n == 1'b0) begin
			samp_1  <= '0;
			samp_2  <= '0;
			stable  <= '0;
			o_press <= '0;
		end else begin
			o_press <= '0;
			if (i_sample) begin
				samp_1  <= i_keys;
				samp_2  <= samp_1;
				stable  <= (agree & samp_1) | (~agree & stable);
				o_press <= rise;	// low to high only
			end
		end
	end

	// Sample ticks are at least two clocks apart, so a press never stretches
	a_press_single: assert property (@(posedge clk) disable iff (rst_n == 1'b0)
		(o_press & $past(o_press)) == '0);

endmodule

// File: src/mode_ctrl.sv
// Mode, position and alarm enable registers stepped by key presses
`timescale 1ns/1ps

module mode_ctrl (
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic [clock_pkg::N_KEYS-1:0] i_press,
	output logic [clock_pkg::MODE_W-1:0] o_mode,
	output logic [clock_pkg::POS_W-1:0]  o_position,
	output logic                         o_alarm_en
);

	import clock_pkg::*;

	// ------------------------------------------------------------
	// CLOCK -> SETUP -> ALARM -> CLOCK
	// ------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (rst_n == 1'b0) begin
			o_mode <= MODE_CLOCK;
		end else if (i_press[KEY_MODE]) begin
			o_mode <= (o_mode >= MODE_ALARM) ? MODE_CLOCK : o_mode + 1'b1;
		end
	end

	// Sec -> min -> hour -> sec
	always_ff @(posedge clk or negedge rst_n) begin
		if (rst_n == 1'b0) begin
			o_position <= POS_SEC;
		end else if (i_press[KEY_POS]) begin
			o_position <= (o_position >= POS_HOUR) ? POS_SEC : o_position + 1'b1;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (rst_n == 1'b0) begin
			o_alarm_en <= 1'b0;
		end else if (i_press[KEY_ALARM]) begin
			o_alarm_en <= ~o_alarm_en;
		end
	end

	// Codes 3 are never reached, whatever the press sequence
	a_mode_range: assert property (@(posedge clk) disable iff (rst_n == 1'b0)
		o_mode <= MODE_ALARM);
	a_pos_range: assert property (@(posedge clk) disable iff (rst_n == 1'b0)
		o_position <= POS_HOUR);

endmodule

// File: src/hms_keeper.sv
// Time of day and alarm time registers, carry chain, unit setting and alarm latch
`timescale 1ns/1ps

module hms_keeper (
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic                         i_sec_tick,
	input  logic                         i_inc,
	input  logic [clock_pkg::MODE_W-1:0] i_mode,
	input  logic [clock_pkg::POS_W-1:0]  i_position,
	input  logic                         i_alarm_en,
	output clock_pkg::hms_time_u         o_disp_time,
	output logic                         o_alarm
);

	import clock_pkg::*;

	hms_time_u         tod;
	hms_time_u         alarm_time;
	hms_time_u         tod_next;
	logic [UNIT_W-1:0] pos_max;
	logic              pos_valid;
	logic              time_match;

	function automatic logic [UNIT_W-1:0] wrap_inc(
		input logic [UNIT_W-1:0] val,
		input logic [UNIT_W-1:0] limit
	);
		return (val >= limit) ? '0 : val + 1'b1;
	endfunction

	function automatic logic in_range(input hms_time_u t);
		return (t.field.sec <= SEC_MAX) && (t.field.min <= MIN_MAX) &&
			(t.field.hour <= HOUR_MAX);
	endfunction

	// ------------------------------------------------------------
	// One second forward, carries settle in the same cycle
	// ------------------------------------------------------------
	always_comb begin
		tod_next = tod;
		tod_next.field.sec = wrap_inc(tod.field.sec, SEC_MAX);
		if (tod.field.sec == SEC_MAX) begin
			tod_next.field.min = wrap_inc(tod.field.min, MIN_MAX);
			if (tod.field.min == MIN_MAX) begin
				tod_next.field.hour = wrap_inc(tod.field.hour, HOUR_MAX);
			end
		end
	end

	// Limit of the unit under the cursor
	always_comb begin
		case (i_position)
			POS_HOUR: pos_max = HOUR_MAX;
			POS_MIN:  pos_max = MIN_MAX;
			default:  pos_max = SEC_MAX;
		endcase
	end

	assign pos_valid = (i_position <= POS_HOUR);

	// Time stands still while it is being set
	always_ff @(posedge clk or negedge rst_n) begin
		if (rst_n == 1'b0) begin
			tod <= '0;
		end else if (i_mode == MODE_SETUP) begin
			if (i_inc && pos_valid) begin
				tod.unit[i_position] <= wrap_inc(tod.unit[i_position], pos_max);
			end
		end else if (i_sec_tick) begin
			tod <= tod_next;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (rst_n == 1'b0) begin
			alarm_time <= '0;
		end else if ((i_mode == MODE_ALARM) && i_inc && pos_valid) begin
			alarm_time.unit[i_position] <= wrap_inc(alarm_time.unit[i_position], pos_max);
		end
	end

	// ------------------------------------------------------------
	// Alarm latch, held until the enable drops
	// ------------------------------------------------------------
	assign time_match = (tod == alarm_time);

	always_ff @(posedge clk or negedge rst_n) begin
		if (rst_n == 1'b0) begin
			o_alarm <= 1'b0;
		end else begin
			o_alarm <= i_alarm_en & (o_alarm | time_match);
		end
	end

	assign o_disp_time = (i_mode == MODE_ALARM) ? alarm_time : tod;

	a_unit_limits: assert property (@(posedge clk) disable iff (rst_n == 1'b0)
		in_range(tod) && in_range(alarm_time));

endmodule

// File: src/seven_seg_scan.sv
// Digit split, segment decoder, six-digit scan and blink of the selected pair
`timescale 1ns/1ps

module seven_seg_scan (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic                           i_scan_tick,
	input  logic                           i_blink_tick,
	input  logic [clock_pkg::MODE_W-1:0]   i_mode,
	input  logic [clock_pkg::POS_W-1:0]    i_position,
	input  clock_pkg::hms_time_u           i_time,
	output logic [clock_pkg::N_DIGITS-1:0] o_seg_enb,
	output logic [clock_pkg::SEG_W-1:0]    o_seg
);

	import clock_pkg::*;

	localparam int IDX_W = $clog2(N_DIGITS);

	logic [IDX_W-1:0]  digit_idx;
	logic              blink;
	logic [POS_W-1:0]  pair;
	logic [UNIT_W-1:0] unit_val;
	logic [3:0]        digit_val;
	logic              blank;

	// Active-low segment codes, a in the MSB
	function automatic logic [SEG_W-1:0] seg_decode(input logic [3:0] num);
		case (num)
			4'd0:    return 7'b000_0001;
			4'd1:    return 7'b100_1111;
			4'd2:    return 7'b001_0010;
			4'd3:    return 7'b000_0110;
			4'd4:    return 7'b100_1100;
			4'd5:    return 7'b010_0100;
			4'd6:    return 7'b010_0000;
			4'd7:    return 7'b000_1111;
			4'd8:    return 7'b000_0000;
			4'd9:    return 7'b000_1100;
			default: return 7'b111_1111;
		endcase
	endfunction

	// ------------------------------------------------------------
	// Scan index and blink phase
	// ------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (rst_n == 1'b0) begin
			digit_idx <= '0;
		end else if (i_scan_tick) begin
			digit_idx <= (digit_idx == IDX_W'(N_DIGITS - 1)) ? '0 : digit_idx + 1'b1;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (rst_n == 1'b0) begin
			blink <= 1'b0;
		end else if (i_blink_tick) begin
			blink <= ~blink;
		end
	end

	// ------------------------------------------------------------
	// Digit select and decode
	// ------------------------------------------------------------
	// Two digits per unit, so the upper index bits give the position code
	assign pair      = digit_idx[IDX_W-1:1];
	assign unit_val  = i_time.unit[pair];
	assign digit_val = digit_idx[0] ? 4'(unit_val / UNIT_W'(10)) : 4'(unit_val % UNIT_W'(10));

	// Selected pair goes dark in the second half of the blink period
	assign blank = (i_mode != MODE_CLOCK) && blink && (pair == i_position);

	assign o_seg_enb = blank ? '1 : ~(N_DIGITS'(1) << digit_idx);
	assign o_seg     = seg_decode(digit_val);

	a_one_digit: assert property (@(posedge clk) disable iff (rst_n == 1'b0)
		$onehot0(~o_seg_enb));

endmodule

// File: src/digital_clock_top.sv
// Top level with the tick dividers, key debounce, mode control, time keeper and display scan
`timescale 1ns/1ps

module digital_clock_top #(
	parameter int SEC_DIV   = clock_pkg::SEC_DIV_DEF,
	parameter int SCAN_DIV  = clock_pkg::SCAN_DIV_DEF,
	parameter int BLINK_DIV = clock_pkg::BLINK_DIV_DEF,
	parameter int KEY_DIV   = clock_pkg::KEY_DIV_DEF
) (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic [clock_pkg::N_KEYS-1:0]   i_keys,
	output logic [clock_pkg::N_DIGITS-1:0] o_seg_enb,
	output logic [clock_pkg::SEG_W-1:0]    o_seg,
	output logic                           o_alarm
);

	import clock_pkg::*;

	logic              sec_tick;
	logic              scan_tick;
	logic              blink_tick;
	logic              key_tick;
	logic [N_KEYS-1:0] press;
	logic [MODE_W-1:0] mode;
	logic [POS_W-1:0]  position;
	logic              alarm_en;
	hms_time_u         disp_time;

	// ------------------------------------------------------------
	// Tick enables, all on clk
	// ------------------------------------------------------------
	tick_gen #(.DIV(SEC_DIV))   u_sec_tick   (.clk(clk), .rst_n(rst_n), .o_tick(sec_tick));
	tick_gen #(.DIV(SCAN_DIV))  u_scan_tick  (.clk(clk), .rst_n(rst_n), .o_tick(scan_tick));
	tick_gen #(.DIV(BLINK_DIV)) u_blink_tick (.clk(clk), .rst_n(rst_n), .o_tick(blink_tick));
	tick_gen #(.DIV(KEY_DIV))   u_key_tick   (.clk(clk), .rst_n(rst_n), .o_tick(key_tick));

	key_debounce u_key_debounce (
		.clk      (clk),
		.rst_n    (rst_n),
		.i_sample (key_tick),
		.i_keys   (i_keys),
		.o_press  (press)
	);

	mode_ctrl u_mode_ctrl (
		.clk        (clk),
		.rst_n      (rst_n),
		.i_press    (press),
		.o_mode     (mode),
		.o_position (position),
		.o_alarm_en (alarm_en)
	);

	hms_keeper u_hms_keeper (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_sec_tick  (sec_tick),
		.i_inc       (press[KEY_INC]),
		.i_mode      (mode),
		.i_position  (position),
		.i_alarm_en  (alarm_en),
		.o_disp_time (disp_time),
		.o_alarm     (o_alarm)
	);

	seven_seg_scan u_seven_seg_scan (
		.clk          (clk),
		.rst_n        (rst_n),
		.i_scan_tick  (scan_tick),
		.i_blink_tick (blink_tick),
		.i_mode       (mode),
		.i_position   (position),
		.i_time       (disp_time),
		.o_seg_enb    (o_seg_enb),
		.o_seg        (o_seg)
	);

endmodule

// File: sim/tb_clk_gen.sv
// Testbench clock and power-on reset generator
`timescale 1ns/1ps

module tb_clk_gen #(
	parameter int PERIOD_NS    = 40,
	parameter int RESET_CYCLES = 3
) (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk;
	end

	// Release on a falling edge, away from the DUT's sampling edge
	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
	end

endmodule

// File: sim/tb_digital_clock.sv
// Testbench for the digital clock with stimulus, display decoding, checks and watchdog
`timescale 1ns/1ps

module tb_digital_clock;

	import clock_pkg::*;

	localparam int     CLK_NS    = 40;
	localparam int     SEC_DIV   = 60;
	localparam int     SCAN_DIV  = 4;
	localparam int     BLINK_DIV = 64;
	localparam int     KEY_DIV   = 2;
	localparam int     MAX_STEPS = 100;
	localparam longint TIMEOUT_NS = longint'(MAX_STEPS) * 4 * SEC_DIV * CLK_NS +
		longint'(200) * SEC_DIV * CLK_NS;
	localparam int     BLANK_CODE = 14;

	logic              clk;
	logic              rst_n;
	logic [N_KEYS-1:0] keys;
	logic [N_DIGITS-1:0] seg_enb;
	logic [SEG_W-1:0]  seg;
	logic              alarm;

	// Expected configuration, updated once a press has fully settled
	logic [MODE_W-1:0] mode_m;
	logic [POS_W-1:0]  pos_m;
	logic              alarm_armed;
	logic              busy;
	logic [31:0]       rng;
	int                last_shown;
	int                hour_tens_seen;
	logic              in_window;
	int                blank_cnt;
	int                shown_cnt;

	tb_clk_gen #(.PERIOD_NS(CLK_NS), .RESET_CYCLES(3)) u_clk_gen (.clk(clk), .rst_n(rst_n));

	digital_clock_top #(
		.SEC_DIV   (SEC_DIV),
		.SCAN_DIV  (SCAN_DIV),
		.BLINK_DIV (BLINK_DIV),
		.KEY_DIV   (KEY_DIV)
	) UUT (
		.clk       (clk),
		.rst_n     (rst_n),
		.i_keys    (keys),
		.o_seg_enb (seg_enb),
		.o_seg     (seg),
		.o_alarm   (alarm)
	);

	// ------------------------------------------------------------
	// Helpers
	// ------------------------------------------------------------
	// Active-low a..g, a in the MSB
	function automatic int seg_to_digit(input logic [SEG_W-1:0] s);
		case (s)
			7'b000_0001: return 0;
			7'b100_1111: return 1;
			7'b001_0010: return 2;
			7'b000_0110: return 3;
			7'b100_1100: return 4;
			7'b010_0100: return 5;
			7'b010_0000: return 6;
			7'b000_1111: return 7;
			7'b000_0000: return 8;
			7'b000_1100: return 9;
			7'b111_1111: return BLANK_CODE;
			default:     return 15;
		endcase
	endfunction

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] s;
		s = x;
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	// A dark cycle follows the last lit digit before the selected pair
	function automatic logic blank_ok(input int last, input logic [POS_W-1:0] pos);
		int lo;
		int prev;
		lo = 2 * int'(pos);
		prev = (lo == 0) ? N_DIGITS - 1 : lo - 1;
		return (last == lo) || (last == prev);
	endfunction

	task automatic abort_run();
		$display("*** TEST FAILED ***");
		$fatal(1, "stopping at first error");
	endtask

	task automatic report_mismatch(input string sig, input string expected, input int actual);
		$display("[FAIL] %0t ns %s expected %s actual %0d", $time, sig, expected, actual);
		abort_run();
	endtask

	task automatic idle_random();
		rng = xorshift32(rng);
		repeat (rng % (2 * SEC_DIV)) @(negedge clk);
	endtask

	task automatic press_key(input int key);
		logic was_armed;
		was_armed = alarm_armed;
		busy = 1'b1;
		if (key == KEY_ALARM) begin
			alarm_armed = 1'b1;
		end
		keys[key] = 1'b1;
		repeat (8 * KEY_DIV) @(negedge clk);
		keys[key] = 1'b0;
		repeat (8 * KEY_DIV) @(negedge clk);
		case (key)
			KEY_MODE:  mode_m = (mode_m == MODE_ALARM) ? MODE_CLOCK : mode_m + 1'b1;
			KEY_POS:   pos_m = (pos_m == POS_HOUR) ? POS_SEC : pos_m + 1'b1;
			KEY_ALARM: alarm_armed = ~was_armed;
			default:   ;
		endcase
		busy = 1'b0;
	endtask

	task automatic read_digit(input int idx, output int val);
		@(negedge clk);
		while (seg_enb[idx] == 1'b1) @(negedge clk);
		val = seg_to_digit(seg);
	endtask

	// Two matching scan rounds, so a carry mid-round is not read
	task automatic read_min_sec(output int mins, output int secs);
		int d0;
		int d1;
		int d2;
		int d3;
		int pm;
		int ps;
		logic done;
		pm = -1;
		ps = -1;
		done = 1'b0;
		while (!done) begin
			read_digit(0, d0);
			read_digit(1, d1);
			read_digit(2, d2);
			read_digit(3, d3);
			secs = d1 * 10 + d0;
			mins = d3 * 10 + d2;
			done = (mins == pm) && (secs == ps);
			pm = mins;
			ps = secs;
		end
	endtask

	task automatic check_blink();
		blank_cnt = 0;
		shown_cnt = 0;
		in_window = 1'b1;
		repeat (4 * BLINK_DIV) @(negedge clk);
		in_window = 1'b0;
		assert (blank_cnt > 0) else report_mismatch("o_seg_enb", "minute pair dark", blank_cnt);
		assert (shown_cnt > 0) else report_mismatch("o_seg_enb", "minute pair lit", shown_cnt);
	endtask

	// ------------------------------------------------------------
	// Display capture at mid-cycle
	// ------------------------------------------------------------
	always @(negedge clk) begin
		for (int i = 0; i < N_DIGITS; i++) begin
			if (seg_enb[i] == 1'b0) begin
				last_shown = i;
			end
		end
		if (seg_enb[5] == 1'b0) begin
			hour_tens_seen = seg_to_digit(seg);
		end
		if (in_window) begin
			if (seg_enb == '1) begin
				blank_cnt++;
			end
			if ((seg_enb[2] == 1'b0) || (seg_enb[3] == 1'b0)) begin
				shown_cnt++;
			end
		end
	end

	// ------------------------------------------------------------
	// Display and alarm checks
	// ------------------------------------------------------------
	a_one_low: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(~seg_enb))
		else report_mismatch("o_seg_enb", "at most one low", $sampled(seg_enb));
	a_seg_code: assert property (@(posedge clk) disable iff (!rst_n)
		(seg_enb != '1) |-> (seg_to_digit(seg) < 10 || seg_to_digit(seg) == BLANK_CODE))
		else report_mismatch("o_seg", "a digit code", $sampled(seg));
	a_sec_tens: assert property (@(posedge clk) disable iff (!rst_n)
		!seg_enb[1] |-> seg_to_digit(seg) <= 5)
		else report_mismatch("o_seg sec tens", "<= 5", seg_to_digit($sampled(seg)));
	a_min_tens: assert property (@(posedge clk) disable iff (!rst_n)
		!seg_enb[3] |-> seg_to_digit(seg) <= 5)
		else report_mismatch("o_seg min tens", "<= 5", seg_to_digit($sampled(seg)));
	a_hour_tens: assert property (@(posedge clk) disable iff (!rst_n)
		!seg_enb[5] |-> seg_to_digit(seg) <= 2)
		else report_mismatch("o_seg hour tens", "<= 2", seg_to_digit($sampled(seg)));
	a_hours: assert property (@(posedge clk) disable iff (!rst_n)
		!seg_enb[4] |-> hour_tens_seen * 10 + seg_to_digit(seg) <= 23)
		else report_mismatch("hours", "<= 23", hour_tens_seen * 10 + seg_to_digit($sampled(seg)));
	a_blank_pair: assert property (@(posedge clk) disable iff (!rst_n || busy)
		(seg_enb == '1) |-> ((mode_m != MODE_CLOCK) && blank_ok(last_shown, pos_m)))
		else report_mismatch("o_seg_enb", "dark only at selected pair", last_shown);
	a_alarm_armed: assert property (@(posedge clk) disable iff (!rst_n) alarm |-> alarm_armed)
		else report_mismatch("o_alarm", "0 while disabled", 1);

	// Watchdog
	initial begin
		#(TIMEOUT_NS);
		$display("Watchdog expired before the test sequence finished");
		abort_run();
	end

	// ------------------------------------------------------------
	// Stimulus
	// ------------------------------------------------------------
	initial begin
		int k;
		int j;
		int mins;
		int secs;
		int s1;
		int diff;
		keys = '0;
		mode_m = MODE_CLOCK;
		pos_m = POS_SEC;
		alarm_armed = 1'b0;
		busy = 1'b0;
		rng = 32'hcf6f;
		last_shown = 0;
		hour_tens_seen = 0;
		in_window = 1'b0;
		blank_cnt = 0;
		shown_cnt = 0;
		rng = xorshift32(rng);
		k = 1 + int'(rng % 64);
		rng = xorshift32(rng);
		j = 1 + int'(rng % 6);
		wait (rst_n == 1'b1);
		@(negedge clk);

		// Enter SETUP before the first second tick, time stays 00:00:00
		press_key(KEY_MODE);
		repeat (k) begin
			idle_random();
			press_key(KEY_INC);
		end
		press_key(KEY_POS);
		repeat (j) begin
			idle_random();
			press_key(KEY_INC);
		end
		read_min_sec(mins, secs);
		assert (mins == j % 60) else report_mismatch("minutes", $sformatf("%0d", j % 60), mins);
		assert (secs == k % 60) else report_mismatch("seconds", $sformatf("%0d", k % 60), secs);
		repeat (3 * SEC_DIV) @(negedge clk);
		read_min_sec(mins, secs);
		assert (mins == j % 60) else report_mismatch("minutes", $sformatf("%0d", j % 60), mins);
		assert (secs == k % 60) else report_mismatch("seconds", $sformatf("%0d", k % 60), secs);
		check_blink();

		// ALARM mode, alarm at 00:(j+2):00
		press_key(KEY_MODE);
		repeat (j + 2) begin
			idle_random();
			press_key(KEY_INC);
		end
		read_min_sec(mins, secs);
		assert (mins == j + 2) else report_mismatch("alarm minutes", $sformatf("%0d", j + 2), mins);
		assert (secs == 0) else report_mismatch("alarm seconds", "0", secs);
		check_blink();
		press_key(KEY_ALARM);
		press_key(KEY_MODE);

		while (alarm == 1'b0) @(negedge clk);
		read_min_sec(mins, secs);
		assert (mins == j + 2) else report_mismatch("minutes at alarm", $sformatf("%0d", j + 2), mins);
		assert (secs <= 1) else report_mismatch("seconds at alarm", "0 or 1", secs);
		repeat (2 * SEC_DIV) @(negedge clk);
		assert (alarm == 1'b1) else report_mismatch("o_alarm", "1 until disabled", alarm);
		press_key(KEY_ALARM);
		assert (alarm == 1'b0) else report_mismatch("o_alarm", "0 after disable", alarm);

		// Time runs in CLOCK mode
		idle_random();
		read_min_sec(mins, s1);
		repeat (10 * SEC_DIV) @(negedge clk);
		read_min_sec(mins, secs);
		diff = (secs - s1 + 60) % 60;
		assert (diff >= 9 && diff <= 11) else report_mismatch("seconds advance", "9 to 11", diff);

		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

// File: filelist.f
src/clock_pkg.sv
src/tick_gen.sv
src/key_debounce.sv
src/mode_ctrl.sv
src/hms_keeper.sv
src/seven_seg_scan.sv
src/digital_clock_top.sv
sim/tb_clk_gen.sv
sim/tb_digital_clock.sv
